// ==== Bender.yml ====
package:
  name: gtx_link

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    defines:
      SIMULATE: ~
    files:
      - logic/gtx_link_pkg.sv
      - logic/gtx_wrap.sv
      - logic/prbs_tx_gen.sv
      - logic/prbs_rx_check.sv
      - logic/link_ctrl_regs.sv
      - logic/gtx_link_top.sv
  - target: test
    include_dirs:
      - logic
    defines:
      SIMULATE: ~
    files:
      - verification/tb_gtx_link.sv

// ==== logic/gtx_link_consts.svh ====
// shared widths, model delays and register map, all offsets assume a 4-bit byte address
`ifndef GTX_LINK_CONSTS_SVH
`define GTX_LINK_CONSTS_SVH

// datapath
`define GTX_DATA_W 20 // transceiver fabric width
`define GTX_PRBS_SEED 20'h5A5A5 // must be nonzero or the lfsr sticks at 0

// behavioural loopback model
`define GTX_LOOP_LAT 4 // tx to rx cycles, at least 2
`define GTX_LOCK_CYCLES 32 // cpll lock after cpllreset falls
`define GTX_RSTDONE_CYCLES 16 // tx/rx reset done after reset falls with lock

// sequencer
// wait budget in WAIT_LOCK and WAIT_DONE before a fresh pll reset,
// keep it above both model delays and below 256
`define GTX_LOCK_TIMEOUT 96

// register byte offsets
`define GTX_REG_CTRL 4'h0 // [0] tx_en, [1] inject pulse, [2] clear pulse
`define GTX_REG_STATUS 4'h4 // [0] link_up, [1] rx_locked
`define GTX_REG_WORDS 4'h8 // checked word count
`define GTX_REG_ERRS 4'hC // error count

`endif

// ==== logic/gtx_link_pkg.sv ====
// types and the prbs step shared by generator, checker and control, one lfsr polynomial only
`include "gtx_link_consts.svh"

package gtx_link_pkg;

	// transceiver bring-up sequence
	typedef enum logic [2:0] {
		PLL_RESET  = 3'd0, // cpllreset held
		WAIT_LOCK  = 3'd1, // cpll lock pending
		GT_RESET   = 3'd2, // tx/rx resets held
		WAIT_DONE  = 3'd3, // reset done pending
		USER_READY = 3'd4, // usrrdy raised
		LINK_UP    = 3'd5
	} rst_state_e;

	// word selectors, byte offset over 4
	typedef enum logic [1:0] {
		REG_CTRL   = 2'(`GTX_REG_CTRL >> 2),
		REG_STATUS = 2'(`GTX_REG_STATUS >> 2),
		REG_WORDS  = 2'(`GTX_REG_WORDS >> 2),
		REG_ERRS   = 2'(`GTX_REG_ERRS >> 2)
	} reg_addr_e;

	// one full word of prbs, x^20 + x^17 + 1 fibonacci form
	function automatic logic [`GTX_DATA_W-1:0] prbs_adv(input logic [`GTX_DATA_W-1:0] s);
		logic [`GTX_DATA_W-1:0] r;
		r = s;
		for (int i = 0; i < `GTX_DATA_W; i++) begin
			r = {r[`GTX_DATA_W-2:0], r[19] ^ r[16]}; // taps 20 and 17
		end
		return r;
	endfunction

endpackage

// ==== logic/gtx_link_top.sv ====
// link test top on the single drpclk_i domain, a hardware build still needs the usrclk crossing
`include "gtx_link_consts.svh"

module gtx_link_top (
	input  logic        drpclk_i,
	input  logic        rst_i,
	input  logic [3:0]  s_awaddr_i,
	input  logic        s_awvalid_i,
	output logic        s_awready_o,
	input  logic [31:0] s_wdata_i,
	input  logic [3:0]  s_wstrb_i,
	input  logic        s_wvalid_i,
	output logic        s_wready_o,
	output logic [1:0]  s_bresp_o,
	output logic        s_bvalid_o,
	input  logic        s_bready_i,
	input  logic [3:0]  s_araddr_i,
	input  logic        s_arvalid_i,
	output logic        s_arready_o,
	output logic [31:0] s_rdata_o,
	output logic [1:0]  s_rresp_o,
	output logic        s_rvalid_o,
	input  logic        s_rready_i,
	input  logic        gtrefclk_p_i,
	input  logic        gtrefclk_n_i,
	input  logic        gt_rxp_i,
	input  logic        gt_rxn_i,
	output logic        gt_txp_o,
	output logic        gt_txn_o
);

	logic                   cpllreset, txreset, rxreset, txusrrdy, rxusrrdy; // sequencer out
	logic                   cpll_locked, txresetdone, rxresetdone;           // gt status
	logic                   tx_en, inject_err, clr_cnt, link_up, rx_locked;
	logic [`GTX_DATA_W-1:0] tx_data, rx_data;
	logic                   tx_valid, rx_valid;
	logic [31:0]            word_cnt, err_cnt;

	link_ctrl_regs u_ctrl (
		.drpclk_i, .rst_i,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o, .s_wdata_i, .s_wstrb_i, .s_wvalid_i,
		.s_wready_o, .s_bresp_o, .s_bvalid_o, .s_bready_i, .s_araddr_i, .s_arvalid_i,
		.s_arready_o, .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.gt_cpllreset_o(cpllreset), .gt_txreset_o(txreset), .gt_rxreset_o(rxreset),
		.gt_txusrrdy_o(txusrrdy), .gt_rxusrrdy_o(rxusrrdy),
		.gt_cpll_locked_i(cpll_locked), .gt_txresetdone_i(txresetdone),
		.gt_rxresetdone_i(rxresetdone),
		.tx_en_o(tx_en), .inject_err_o(inject_err), .clr_cnt_o(clr_cnt), .link_up_o(link_up),
		.rx_locked_i(rx_locked), .word_cnt_i(word_cnt), .err_cnt_i(err_cnt)
	);

	prbs_tx_gen u_gen (
		.drpclk_i, .rst_i,
		.tx_en_i(tx_en), .link_up_i(link_up), .inject_err_i(inject_err),
		.tx_data_o(tx_data), .tx_valid_o(tx_valid)
	);

	prbs_rx_check u_chk (
		.drpclk_i, .rst_i,
		.clr_cnt_i(clr_cnt), .rx_data_i(rx_data), .rx_valid_i(rx_valid),
		.rx_locked_o(rx_locked), .word_cnt_o(word_cnt), .err_cnt_o(err_cnt)
	);

	// serial pins pass straight to the channel
	gtx_wrap u_gt (
		.gtrefclk_p_i, .gtrefclk_n_i, .drpclk_i, .rst_i,
		.gt_rxp_i, .gt_rxn_i, .gt_txp_o, .gt_txn_o,
		.gt_cpllreset_i(cpllreset), .gt_txreset_i(txreset), .gt_rxreset_i(rxreset),
		.gt_txusrrdy_i(txusrrdy), .gt_rxusrrdy_i(rxusrrdy),
		.gt_txdata_i(tx_data), .gt_txvalid_i(tx_valid),
		.gt_rxdata_o(rx_data), .gt_rxvalid_o(rx_valid),
		.gt_cpll_locked_o(cpll_locked), .gt_txresetdone_o(txresetdone),
		.gt_rxresetdone_o(rxresetdone)
	);

endmodule

// ==== logic/gtx_wrap.sv ====
// one gtx channel as an internal loopback model on drpclk_i
`include "gtx_link_consts.svh"

module gtx_wrap (
	input  logic                   gtrefclk_p_i,
	input  logic                   gtrefclk_n_i,
	input  logic                   drpclk_i,
	input  logic                   rst_i,
	input  logic                   gt_rxp_i,
	input  logic                   gt_rxn_i,
	output logic                   gt_txp_o,
	output logic                   gt_txn_o,
	input  logic                   gt_cpllreset_i,
	input  logic                   gt_txreset_i,
	input  logic                   gt_rxreset_i,
	input  logic                   gt_txusrrdy_i,
	input  logic                   gt_rxusrrdy_i,
	input  logic [`GTX_DATA_W-1:0] gt_txdata_i,
	input  logic                   gt_txvalid_i,
	output logic [`GTX_DATA_W-1:0] gt_rxdata_o,
	output logic                   gt_rxvalid_o,
	output logic                   gt_cpll_locked_o,
	output logic                   gt_txresetdone_o,
	output logic                   gt_rxresetdone_o
);

	localparam int CNT_W = 8;
	// counter 0 is cpll lock, 1 is tx done, 2 is rx done
	localparam logic [2:0][CNT_W-1:0] LIMIT = {CNT_W'(`GTX_RSTDONE_CYCLES),
		CNT_W'(`GTX_RSTDONE_CYCLES), CNT_W'(`GTX_LOCK_CYCLES)};

	logic [2:0][CNT_W-1:0]                    cnt_q;
	logic [2:0]                               hold;  // counter held at zero
	logic [2:0]                               done;
	logic [`GTX_LOOP_LAT-1:0][`GTX_DATA_W-1:0] dly_data;
	logic [`GTX_LOOP_LAT-1:0]                 dly_vld;

	assign gt_txp_o = 1'b0; // pins idle, loopback is internal
	assign gt_txn_o = 1'b1;

	// resets done only count once lock is there
	assign hold = {gt_rxreset_i | ~done[0], gt_txreset_i | ~done[0], gt_cpllreset_i};

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			done[i] = (cnt_q[i] == LIMIT[i]);
		end
	end

	always_ff @(posedge drpclk_i) begin
		for (int i = 0; i < 3; i++) begin
			if (rst_i || hold[i]) begin
				cnt_q[i] <= '0;
			end else if (!done[i]) begin
				cnt_q[i] <= cnt_q[i] + 1'b1; // saturates at its limit
			end
		end
	end

	assign gt_cpll_locked_o = done[0];
	assign gt_txresetdone_o = done[1];
	assign gt_rxresetdone_o = done[2];

	// loopback line, several words in flight
	always_ff @(posedge drpclk_i) begin
		dly_data <= {dly_data[`GTX_LOOP_LAT-2:0], gt_txdata_i};
		if (rst_i) begin
			dly_vld <= '0;
		end else begin
			dly_vld <= {dly_vld[`GTX_LOOP_LAT-2:0],
				gt_txvalid_i & gt_txusrrdy_i & gt_rxusrrdy_i}; // both sides ready
		end
	end

	assign gt_rxdata_o  = dly_data[`GTX_LOOP_LAT-1];
	assign gt_rxvalid_o = dly_vld[`GTX_LOOP_LAT-1];

endmodule

// ==== logic/link_ctrl_regs.sv ====
// axi4-lite slave with one command in flight, only wstrb[0] is honoured and responses are OKAY
`include "gtx_link_consts.svh"

module link_ctrl_regs (
	input  logic        drpclk_i,
	input  logic        rst_i,
	// axi4-lite slave
	input  logic [3:0]  s_awaddr_i,
	input  logic        s_awvalid_i,
	output logic        s_awready_o,
	input  logic [31:0] s_wdata_i,
	input  logic [3:0]  s_wstrb_i,
	input  logic        s_wvalid_i,
	output logic        s_wready_o,
	output logic [1:0]  s_bresp_o,
	output logic        s_bvalid_o,
	input  logic        s_bready_i,
	input  logic [3:0]  s_araddr_i,
	input  logic        s_arvalid_i,
	output logic        s_arready_o,
	output logic [31:0] s_rdata_o,
	output logic [1:0]  s_rresp_o,
	output logic        s_rvalid_o,
	input  logic        s_rready_i,
	// transceiver resets
	output logic        gt_cpllreset_o,
	output logic        gt_txreset_o,
	output logic        gt_rxreset_o,
	output logic        gt_txusrrdy_o,
	output logic        gt_rxusrrdy_o,
	input  logic        gt_cpll_locked_i,
	input  logic        gt_txresetdone_i,
	input  logic        gt_rxresetdone_i,
	// datapath control and status
	output logic        tx_en_o,
	output logic        inject_err_o,
	output logic        clr_cnt_o,
	output logic        link_up_o,
	input  logic        rx_locked_i,
	input  logic [31:0] word_cnt_i,
	input  logic [31:0] err_cnt_i
);

	localparam logic [7:0] RST_HOLD = 8'd4; // cycles each reset phase is held

	gtx_link_pkg::rst_state_e state_q, state_d;
	logic [7:0]               timer_q; // cycles in current state
	logic                     tmo;
	logic                     wr_rdy_q, wr_fire, rd_fire;
	logic                     ctrl_wr;
	logic [31:0]              rd_word;

	assign tmo = (timer_q == 8'(`GTX_LOCK_TIMEOUT - 1));

	always_comb begin
		state_d = state_q;
		case (state_q)
			gtx_link_pkg::PLL_RESET: if (timer_q == RST_HOLD - 1'b1) state_d = gtx_link_pkg::WAIT_LOCK;
			gtx_link_pkg::WAIT_LOCK: begin
				if (gt_cpll_locked_i) state_d = gtx_link_pkg::GT_RESET;
				else if (tmo) state_d = gtx_link_pkg::PLL_RESET; // retry from scratch
			end
			gtx_link_pkg::GT_RESET: if (timer_q == RST_HOLD - 1'b1) state_d = gtx_link_pkg::WAIT_DONE;
			gtx_link_pkg::WAIT_DONE: begin
				if (!gt_cpll_locked_i || tmo) state_d = gtx_link_pkg::PLL_RESET;
				else if (gt_txresetdone_i && gt_rxresetdone_i) state_d = gtx_link_pkg::USER_READY;
			end
			gtx_link_pkg::USER_READY: state_d = gtx_link_pkg::LINK_UP;
			gtx_link_pkg::LINK_UP: begin
				// lost lock or a reset dropped out
				if (!gt_cpll_locked_i || !gt_txresetdone_i || !gt_rxresetdone_i)
					state_d = gtx_link_pkg::PLL_RESET;
			end
			default: state_d = gtx_link_pkg::PLL_RESET;
		endcase
	end

	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			state_q <= gtx_link_pkg::PLL_RESET;
			timer_q <= '0;
		end else begin
			state_q <= state_d;
			timer_q <= (state_d != state_q) ? 8'd0 : timer_q + 1'b1;
		end
	end

	// gt resets stay high until the pll is locked
	assign gt_cpllreset_o = (state_q == gtx_link_pkg::PLL_RESET);
	assign gt_txreset_o   = (state_q inside {gtx_link_pkg::PLL_RESET, gtx_link_pkg::WAIT_LOCK,
		gtx_link_pkg::GT_RESET});
	assign gt_rxreset_o   = gt_txreset_o;
	assign gt_txusrrdy_o  = (state_q inside {gtx_link_pkg::USER_READY, gtx_link_pkg::LINK_UP});
	assign gt_rxusrrdy_o  = gt_txusrrdy_o;
	assign link_up_o      = (state_q == gtx_link_pkg::LINK_UP);

	// write channel, aw and w taken together
	assign s_awready_o = wr_rdy_q;
	assign s_wready_o  = wr_rdy_q;
	assign wr_fire     = wr_rdy_q & s_awvalid_i & s_wvalid_i;
	assign ctrl_wr     = wr_fire & s_wstrb_i[0]
		& (gtx_link_pkg::reg_addr_e'(s_awaddr_i[3:2]) == gtx_link_pkg::REG_CTRL);
	assign s_bresp_o   = 2'b00;
	assign s_rresp_o   = 2'b00;

	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			wr_rdy_q   <= 1'b0;
			s_bvalid_o <= 1'b0;
		end else begin
			// one-cycle ready, nothing new while b is pending
			wr_rdy_q <= ~wr_rdy_q & s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
			if (wr_fire) s_bvalid_o <= 1'b1;
			else if (s_bready_i) s_bvalid_o <= 1'b0;
		end
	end

	// ctrl bits, 1 and 2 are pulses only
	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			tx_en_o      <= 1'b0;
			inject_err_o <= 1'b0;
			clr_cnt_o    <= 1'b0;
		end else begin
			inject_err_o <= ctrl_wr & s_wdata_i[1];
			clr_cnt_o    <= ctrl_wr & s_wdata_i[2];
			if (ctrl_wr) tx_en_o <= s_wdata_i[0];
		end
	end

	// read mux
	always_comb begin
		case (gtx_link_pkg::reg_addr_e'(s_araddr_i[3:2]))
			gtx_link_pkg::REG_CTRL:   rd_word = {31'd0, tx_en_o};
			gtx_link_pkg::REG_STATUS: rd_word = {30'd0, rx_locked_i, link_up_o};
			gtx_link_pkg::REG_WORDS:  rd_word = word_cnt_i;
			gtx_link_pkg::REG_ERRS:   rd_word = err_cnt_i;
			default:                  rd_word = 32'd0;
		endcase
	end

	assign rd_fire = s_arready_o & s_arvalid_i;

	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			s_arready_o <= 1'b0;
			s_rvalid_o  <= 1'b0;
		end else begin
			s_arready_o <= ~s_arready_o & s_arvalid_i & ~s_rvalid_o; // one-cycle pulse
			if (rd_fire) s_rvalid_o <= 1'b1;
			else if (s_rready_i) s_rvalid_o <= 1'b0;
		end
	end

	// data sampled at accept, held with rvalid
	always_ff @(posedge drpclk_i) begin
		if (rd_fire) s_rdata_o <= rd_word;
	end

endmodule

// ==== logic/prbs_rx_check.sv ====
// self-synchronising prbs-20 checker; one bad word counts as two errors since it seeds the next guess
`include "gtx_link_consts.svh"

module prbs_rx_check (
	input  logic                   drpclk_i,
	input  logic                   rst_i,
	input  logic                   clr_cnt_i,   // one-cycle pulse
	input  logic [`GTX_DATA_W-1:0] rx_data_i,
	input  logic                   rx_valid_i,
	output logic                   rx_locked_o,
	output logic [31:0]            word_cnt_o,
	output logic [31:0]            err_cnt_o
);

	logic [`GTX_DATA_W-1:0] last_q;  // previous received word
	logic [`GTX_DATA_W-1:0] expect_w;
	logic                   check;
	logic                   miss;

	assign expect_w = gtx_link_pkg::prbs_adv(last_q);
	assign check    = rx_valid_i & rx_locked_o; // first word only seeds
	assign miss     = check & (rx_data_i != expect_w);

	// reference word, no reset needed
	always_ff @(posedge drpclk_i) begin
		if (rx_valid_i) begin
			last_q <= rx_data_i;
		end
	end

	// lock on first valid word
	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			rx_locked_o <= 1'b0;
		end else if (rx_valid_i) begin
			rx_locked_o <= 1'b1; // survives clr_cnt
		end
	end

	// word counter
	always_ff @(posedge drpclk_i) begin
		if (rst_i || clr_cnt_i) begin
			word_cnt_o <= '0;
		end else if (check) begin
			word_cnt_o <= word_cnt_o + 1'b1;
		end
	end

	// error counter
	always_ff @(posedge drpclk_i) begin
		if (rst_i || clr_cnt_i) begin
			err_cnt_o <= '0;
		end else if (miss) begin
			err_cnt_o <= err_cnt_o + 1'b1; // wraps, no saturation
		end
	end

endmodule

// ==== logic/prbs_tx_gen.sv ====
// prbs-20 source at one word per cycle while enabled and link up, the first word follows the seed
`include "gtx_link_consts.svh"

module prbs_tx_gen (
	input  logic                   drpclk_i,
	input  logic                   rst_i,
	input  logic                   tx_en_i,
	input  logic                   link_up_i,
	input  logic                   inject_err_i, // one-cycle request
	output logic [`GTX_DATA_W-1:0] tx_data_o,
	output logic                   tx_valid_o
);

	logic [`GTX_DATA_W-1:0] lfsr_q;  // clean pattern state
	logic                   step_q;  // state advanced last cycle
	logic                   inj_pend_q;
	logic                   run;
	logic                   flip;

	assign run  = tx_en_i & link_up_i;
	assign flip = inj_pend_q & step_q; // next emitted word takes the error

	// state register, 20 steps per word
	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			lfsr_q <= `GTX_PRBS_SEED;
			step_q <= 1'b0;
		end else begin
			step_q <= run;
			if (run) begin
				lfsr_q <= gtx_link_pkg::prbs_adv(lfsr_q);
			end
		end
	end

	// held request until a word goes out
	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			inj_pend_q <= 1'b0;
		end else begin
			inj_pend_q <= (inj_pend_q & ~step_q) | inject_err_i;
		end
	end

	// output stage, one cycle behind the state
	always_ff @(posedge drpclk_i) begin
		if (rst_i) begin
			tx_valid_o <= 1'b0;
		end else begin
			tx_valid_o <= step_q;
		end
	end

	always_ff @(posedge drpclk_i) begin
		if (step_q) begin
			// bit 0 flip only, lfsr_q stays clean
			tx_data_o <= lfsr_q ^ {{(`GTX_DATA_W-1){1'b0}}, flip};
		end
	end

endmodule

// ==== project.f ====
+incdir+logic
logic/gtx_link_pkg.sv
logic/gtx_wrap.sv
logic/prbs_tx_gen.sv
logic/prbs_rx_check.sv
logic/link_ctrl_regs.sv
logic/gtx_link_top.sv
verification/tb_gtx_link.sv

// ==== verification/tb_gtx_link.sv ====
// needs the SIMULATE loopback model; tx and rx words are watched through the DUT hierarchy
`include "gtx_link_consts.svh"

module tb_gtx_link;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HS_TMO     = 64;  // cycles per axi handshake
	localparam int LINK_POLLS = 100; // status reads before giving up
	localparam int DRAIN_TMO  = 200; // cycles for the loopback to empty

	logic        clk, rst;
	logic [3:0]  awaddr, araddr;
	logic        awvalid, wvalid, bready, arvalid, rready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        awready, wready, bvalid, arready, rvalid;
	logic [1:0]  bresp, rresp;
	logic [31:0] rdata;
	logic        txp, txn;

	int                     errors, checks, sent_cnt, inj_seen;
	logic                   inj_armed;
	logic [`GTX_DATA_W-1:0] ref_word; // reference pattern state

	gtx_link_top DUT (
		.drpclk_i(clk), .rst_i(rst),
		.s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
		.s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
		.s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
		.s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
		.s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
		.gtrefclk_p_i(1'b0), .gtrefclk_n_i(1'b1), // unused by the model
		.gt_rxp_i(1'b0), .gt_rxn_i(1'b1), .gt_txp_o(txp), .gt_txn_o(txn)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns
	end

	// x^20 + x^17 + 1, twenty shifts per word
	function automatic logic [`GTX_DATA_W-1:0] prbs_next(input logic [`GTX_DATA_W-1:0] s);
		logic [`GTX_DATA_W-1:0] r;
		r = s;
		for (int i = 0; i < 20; i++) begin
			r = {r[18:0], r[19] ^ r[16]};
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic close_test(input string name, input int errs_before);
		$display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		int n;
		@(posedge clk);
		#1;
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hF;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!(awready && wready) && n < HS_TMO);
		@(posedge clk); // transfer edge
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		if (n >= HS_TMO) begin
			$display("write address/data handshake timed out at 0x%0h", addr);
			errors++;
			return;
		end
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!bvalid && n < HS_TMO);
		if (!bvalid) begin
			$display("write response never arrived for 0x%0h", addr);
			errors++;
		end else begin
			check_val("bresp", bresp, 0); // OKAY
		end
	endtask

	// stall holds rready low that many cycles with rvalid up
	task automatic axi_read(input logic [3:0] addr, input int stall, output logic [31:0] data);
		int n;
		data = '0;
		@(posedge clk);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		rready  = (stall == 0);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!arready && n < HS_TMO);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		if (n >= HS_TMO) begin
			$display("read address handshake timed out at 0x%0h", addr);
			errors++;
			rready = 1'b1;
			return;
		end
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rvalid && n < HS_TMO);
		if (!rvalid) begin
			$display("read data never arrived for 0x%0h", addr);
			errors++;
			rready = 1'b1;
			return;
		end
		data = rdata;
		check_val("rresp", rresp, 0); // OKAY
		if (stall > 0) begin
			repeat (stall) begin
				@(negedge clk);
				check_val("rvalid", rvalid, 1);
				check_val("rdata", rdata, data); // must not move while stalled
			end
			@(posedge clk);
			#1 rready = 1'b1;
			@(negedge clk);
			check_val("rvalid", rvalid, 1); // taken on the next edge
			@(negedge clk);
			check_val("rvalid", rvalid, 0);
		end
	endtask

	// quiet on both tx and rx long enough for the counters to settle
	task automatic wait_idle();
		int quiet;
		int n;
		quiet = 0;
		n = 0;
		while (quiet < `GTX_LOOP_LAT + 4 && n < DRAIN_TMO) begin
			@(negedge clk);
			n++;
			quiet = (DUT.tx_valid || DUT.rx_valid) ? 0 : quiet + 1;
		end
		if (quiet < `GTX_LOOP_LAT + 4) begin
			$display("datapath did not drain");
			errors++;
		end
	endtask

	// tx monitor, each sent word against the reference chain from the seed
	always @(negedge clk) begin
		if (rst) begin
			ref_word = `GTX_PRBS_SEED;
		end else if (DUT.tx_valid) begin
			ref_word = prbs_next(ref_word);
			if (inj_armed && DUT.tx_data === (ref_word ^ 20'h1)) begin
				inj_seen++; // the one expected bit-0 flip
				inj_armed = 1'b0;
			end else begin
				check_val("tx_data", 32'(DUT.tx_data), 32'(ref_word));
			end
			sent_cnt++;
		end
	end

	initial begin
		#100us;
		$display("simulation ran past its time limit");
		$display("Checks failed");
		$finish;
	end

	initial begin
		int          mark, n, cycles, sent0;
		logic [31:0] rd, words0, errs0;
		errors    = 0;
		checks    = 0;
		sent_cnt  = 0;
		inj_seen  = 0;
		inj_armed = 1'b0;
		void'($urandom(90));
		rst     = 1'b1;
		awaddr  = '0;
		araddr  = '0;
		wdata   = '0;
		wstrb   = '0;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		arvalid = 1'b0;
		rready  = 1'b1;

		// 1: reset state
		mark = errors;
		@(negedge clk);
		check_val("aw/w/b/ar/r handshakes in reset", {awready, wready, bvalid, arready, rvalid}, 0);
		repeat (2) @(posedge clk); // three reset edges in all
		#1 rst = 1'b0;
		@(negedge clk);
		check_val("aw/w/b/ar/r handshakes after reset", {awready, wready, bvalid, arready, rvalid}, 0);
		check_val("gt_txp_o ^ gt_txn_o", txp ^ txn, 1); // differential pair
		axi_read(`GTX_REG_STATUS, 0, rd);
		check_val("STATUS.link_up", rd[0], 0);
		axi_read(`GTX_REG_WORDS, 0, rd);
		check_val("WORDS", rd, 0);
		axi_read(`GTX_REG_ERRS, 0, rd);
		check_val("ERRS", rd, 0);
		close_test("1 reset", mark);

		// 2: bring-up
		mark = errors;
		n = 0;
		rd = '0;
		while (!rd[0] && n < LINK_POLLS) begin
			axi_read(`GTX_REG_STATUS, 0, rd);
			n++;
		end
		if (!rd[0]) begin
			$display("link did not come up");
			errors++;
		end
		close_test("2 link up", mark);

		// 3: clean traffic for a random time
		mark = errors;
		cycles = 50 + ($urandom % 151);
		axi_write(`GTX_REG_CTRL, 32'h1);
		repeat (cycles) @(posedge clk);
		axi_write(`GTX_REG_CTRL, 32'h0);
		wait_idle();
		axi_read(`GTX_REG_ERRS, 0, rd);
		check_val("ERRS", rd, 0);
		axi_read(`GTX_REG_WORDS, 0, rd);
		check_val("WORDS", rd, sent_cnt - 1); // first word only seeds the checker
		close_test("3 traffic", mark);

		// 4: one injected bit error
		mark = errors;
		axi_read(`GTX_REG_WORDS, 0, words0);
		axi_read(`GTX_REG_ERRS, 0, errs0);
		sent0 = sent_cnt;
		axi_write(`GTX_REG_CTRL, 32'h1);
		repeat (20) @(posedge clk);
		inj_armed = 1'b1;
		axi_write(`GTX_REG_CTRL, 32'h3); // tx_en kept, inject pulse
		repeat (30) @(posedge clk); // the word after the bad one must go out too
		axi_write(`GTX_REG_CTRL, 32'h0);
		wait_idle();
		axi_read(`GTX_REG_ERRS, 0, rd);
		check_val("ERRS", rd, errs0 + 2);
		axi_read(`GTX_REG_WORDS, 0, rd);
		check_val("WORDS", rd, words0 + (sent_cnt - sent0));
		check_val("injected tx words", inj_seen, 1);
		close_test("4 error injection", mark);

		// 5: counter clear
		mark = errors;
		axi_write(`GTX_REG_CTRL, 32'h4);
		axi_read(`GTX_REG_WORDS, 0, rd);
		check_val("WORDS", rd, 0);
		axi_read(`GTX_REG_ERRS, 0, rd);
		check_val("ERRS", rd, 0);
		axi_read(`GTX_REG_STATUS, 0, rd);
		check_val("STATUS.rx_locked", rd[1], 1);
		close_test("5 counter clear", mark);

		// 6: read held back by rready
		mark = errors;
		cycles = 1 + ($urandom % 8);
		axi_read(`GTX_REG_STATUS, cycles, rd);
		check_val("STATUS", rd, 32'h3); // link_up and rx_locked
		close_test("6 read back-pressure", mark);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
